/* all.f */
core_pkg.sv
bank_if.sv
poly_bank.sv
coeff_counter.sv
mod_mac.sv
pwm_controller.sv
compute_core.sv
compute_core_properties.sv
compute_core_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module compute_core_tb -f all.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "All tests passed" && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation reported failure"; exit 1; }

/* compute_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module compute_core_tb;

  localparam int N               = core_pkg::N;
  localparam int NUM_TESTS       = 7;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (3 * N * 8 + N + 20);
  localparam int POLL_LIMIT      = 4 * N;
  localparam int OVERLAP_IDX     = 37;

  localparam core_pkg::apb_addr_t CMD_ADDR    = {core_pkg::REGION_CTRL, 6'd0, 2'b00};
  localparam core_pkg::apb_addr_t STATUS_ADDR = {core_pkg::REGION_CTRL, 6'd1, 2'b00};

  typedef struct packed {
    core_pkg::opcode_t op;
    core_pkg::coeff_t  q;
    logic              reject;
    logic              overlap;
  } test_entry_t;

  logic                clk;
  logic                rst;
  logic                psel;
  logic                penable;
  logic                pwrite;
  core_pkg::apb_addr_t paddr;
  core_pkg::apb_data_t pwdata;
  core_pkg::apb_data_t prdata;
  logic                pready;
  logic                pslverr;
  logic                done;

  test_entry_t      tests [NUM_TESTS];
  core_pkg::coeff_t model_a [N];
  core_pkg::coeff_t model_b [N];
  core_pkg::coeff_t model_c [N];
  core_pkg::coeff_t expect_c [N];
  logic             model_done;
  logic [31:0]      lcg_state;
  int               errors;
  int               checks;
  int               failed_tests;

  compute_core DUT (
    .clk    (clk),
    .rst    (rst),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr(pslverr),
    .done   (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  // opcode, modulus, rejected, poly read overlapped with busy
  task automatic fill_table();
    tests[0] = '{op: core_pkg::OP_PWM,  q: 17'd12289,  reject: 1'b0, overlap: 1'b0};
    tests[1] = '{op: core_pkg::OP_PWM,  q: 17'd131071, reject: 1'b0, overlap: 1'b0};
    tests[2] = '{op: core_pkg::OP_PMAC, q: 17'd12289,  reject: 1'b0, overlap: 1'b0};
    tests[3] = '{op: core_pkg::OP_PWM,  q: 17'd7681,   reject: 1'b0, overlap: 1'b1};
    tests[4] = '{op: core_pkg::OP_PMAC, q: 17'd65537,  reject: 1'b0, overlap: 1'b1};
    tests[5] = '{op: 3'd5,              q: 17'd12289,  reject: 1'b1, overlap: 1'b0};
    tests[6] = '{op: core_pkg::OP_PMAC, q: 17'd0,      reject: 1'b1, overlap: 1'b0};
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_coeff(input core_pkg::coeff_t q, output core_pkg::coeff_t v);
    lcg_state = lcg_next(lcg_state);
    v = core_pkg::coeff_t'({8'd0, lcg_state[31:8]} % {15'd0, q});
  endtask

  // reference from c = (acc ? c : 0) + a*b mod q
  function automatic core_pkg::coeff_t mac_reference(input core_pkg::coeff_t a,
                                                     input core_pkg::coeff_t b,
                                                     input core_pkg::coeff_t c,
                                                     input core_pkg::coeff_t q,
                                                     input logic acc);
    logic [63:0] sum;
    sum = 64'(a) * 64'(b);
    if (acc) begin
      sum = sum + 64'(c);
    end
    return core_pkg::coeff_t'(sum % 64'(q));
  endfunction

  function automatic logic [1:0] status_bits(input logic busy_bit, input logic done_bit);
    logic [1:0] s;
    s = '0;
    s[core_pkg::STATUS_BUSY_BIT] = busy_bit;
    s[core_pkg::STATUS_DONE_BIT] = done_bit;
    return s;
  endfunction

  function automatic core_pkg::apb_addr_t poly_addr(input core_pkg::region_t r, input int idx);
    return {r, core_pkg::coeff_idx_t'(idx), 2'b00};
  endfunction

  function automatic core_pkg::apb_data_t cmd_word(input core_pkg::opcode_t op,
                                                   input core_pkg::coeff_t q);
    return core_pkg::apb_data_t'({q, op});
  endfunction

  function automatic core_pkg::coeff_t model_value(input core_pkg::region_t r, input int idx);
    case (r)
      core_pkg::REGION_A: return model_a[idx];
      core_pkg::REGION_B: return model_b[idx];
      default:            return model_c[idx];
    endcase
  endfunction

  task automatic check_coeff(input string what, input int idx,
                             input core_pkg::coeff_t got, input core_pkg::coeff_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t: %s[%0d] read %0d, expected %0d", $time, what, idx, got, exp);
    end
  endtask

  task automatic check_status(input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t: status busy %0b done %0b, expected busy %0b done %0b", $time,
               got[core_pkg::STATUS_BUSY_BIT], got[core_pkg::STATUS_DONE_BIT],
               exp[core_pkg::STATUS_BUSY_BIT], exp[core_pkg::STATUS_DONE_BIT]);
    end
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t: %s gave pslverr %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_done(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t: done output %0b, expected %0b", $time, got, exp);
    end
  endtask

  // setup cycle, then access cycles until pready
  task automatic apb_transfer(input logic write, input core_pkg::apb_addr_t addr,
                              input core_pkg::apb_data_t wdata,
                              output core_pkg::apb_data_t rdata, output logic err,
                              output int waits);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    waits = 0;
    @(negedge clk);
    while (!pready) begin
      waits++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic write_word(input core_pkg::apb_addr_t addr, input core_pkg::apb_data_t data,
                            input logic exp_err, input string what);
    core_pkg::apb_data_t rd;
    logic                err;
    int                  waits;
    apb_transfer(1'b1, addr, data, rd, err, waits);
    check_err(what, err, exp_err);
  endtask

  task automatic read_word(input core_pkg::apb_addr_t addr, output core_pkg::apb_data_t data,
                           output int waits);
    logic err;
    apb_transfer(1'b0, addr, 32'h0, data, err, waits);
    check_err("read", err, 1'b0);
  endtask

  task automatic read_status(output logic [1:0] st);
    core_pkg::apb_data_t data;
    int                  waits;
    read_word(STATUS_ADDR, data, waits);
    st = status_bits(data[core_pkg::STATUS_BUSY_BIT], data[core_pkg::STATUS_DONE_BIT]);
  endtask

  task automatic poll_idle(output logic [1:0] st);
    int polls;
    polls = 0;
    read_status(st);
    while (st[core_pkg::STATUS_BUSY_BIT] && polls < POLL_LIMIT) begin
      polls++;
      read_status(st);
    end
  endtask

  task automatic load_polys(input core_pkg::coeff_t q);
    for (int i = 0; i < N; i++) begin
      draw_coeff(q, model_a[i]);
      draw_coeff(q, model_b[i]);
      draw_coeff(q, model_c[i]);
      write_word(poly_addr(core_pkg::REGION_A, i), 32'(model_a[i]), 1'b0, "write a");
      write_word(poly_addr(core_pkg::REGION_B, i), 32'(model_b[i]), 1'b0, "write b");
      write_word(poly_addr(core_pkg::REGION_C, i), 32'(model_c[i]), 1'b0, "write c");
    end
  endtask

  task automatic verify_poly(input core_pkg::region_t r, input string name);
    core_pkg::apb_data_t data;
    int                  waits;
    for (int i = 0; i < N; i++) begin
      read_word(poly_addr(r, i), data, waits);
      check_coeff(name, i, core_pkg::coeff_t'(data), model_value(r, i));
    end
  endtask

  task automatic run_test(input int t);
    test_entry_t         e;
    logic [1:0]          st_before;
    logic [1:0]          st;
    core_pkg::apb_data_t data;
    core_pkg::opcode_t   other_op;
    int                  waits;
    int                  errors_before;
    e = tests[t];
    errors_before = errors;
    if (e.reject) begin
      read_status(st_before);
      check_status(st_before, status_bits(1'b0, model_done));
      write_word(CMD_ADDR, cmd_word(e.op, e.q), 1'b1, "invalid command");
      read_status(st);
      check_status(st, status_bits(1'b0, model_done));
      @(negedge clk);
      check_done(done, model_done);
      verify_poly(core_pkg::REGION_C, "c");
    end else begin
      load_polys(e.q);
      verify_poly(core_pkg::REGION_C, "c");
      for (int i = 0; i < N; i++) begin
        expect_c[i] = mac_reference(model_a[i], model_b[i], model_c[i], e.q,
                                    e.op == core_pkg::OP_PMAC);
      end
      write_word(CMD_ADDR, cmd_word(e.op, e.q), 1'b0, "command");
      if (e.overlap) begin
        // valid on its own, refused only because the engine is busy
        other_op = (e.op == core_pkg::OP_PWM) ? core_pkg::OP_PMAC : core_pkg::OP_PWM;
        write_word(CMD_ADDR, cmd_word(other_op, 17'd3), 1'b1, "command while busy");
        read_word(poly_addr(core_pkg::REGION_C, OVERLAP_IDX), data, waits);
        check_coeff("c read during busy", OVERLAP_IDX, core_pkg::coeff_t'(data),
                    expect_c[OVERLAP_IDX]);
        checks++;
        if (waits <= N) begin
          errors++;
          $display("poly read during busy was not held off, it took only %0d wait cycles", waits);
        end
      end
      poll_idle(st);
      check_status(st, status_bits(1'b0, 1'b1));
      @(negedge clk);
      check_done(done, 1'b1);
      model_done = 1'b1;
      for (int i = 0; i < N; i++) begin
        model_c[i] = expect_c[i];
      end
      verify_poly(core_pkg::REGION_C, "c");
      verify_poly(core_pkg::REGION_A, "a");
      verify_poly(core_pkg::REGION_B, "b");
    end
    if (errors == errors_before) begin
      $display("test %0d op %0d q %0d: ok", t, e.op, e.q);
    end else begin
      failed_tests++;
      $display("test %0d op %0d q %0d: %0d errors", t, e.op, e.q, errors - errors_before);
    end
  endtask

  initial begin
    logic [1:0] st;
    rst          = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    lcg_state    = 32'hfa38_ef1c;
    model_done   = 1'b0;
    errors       = 0;
    checks       = 0;
    failed_tests = 0;
    fill_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    read_status(st);
    check_status(st, status_bits(1'b0, 1'b0));
    @(negedge clk);
    check_done(done, 1'b0);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    errors = errors + DUT.u_properties.fail_count;
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             NUM_TESTS, failed_tests, checks, errors, DUT.u_properties.fail_count);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compute_core_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module compute_core_properties (
  input logic clk,
  input logic rst,
  input logic busy,
  input logic done,
  input logic wr_en,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr
);

  // number of assertion failures so far
  int fail_count = 0;

  busy_done_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(busy && done)
  ) else begin
    $error("busy and done are high together");
    fail_count++;
  end

  // engine writes to c only while a command runs
  engine_we_in_busy: assert property (
    @(posedge clk) disable iff (rst) wr_en |-> busy
  ) else begin
    $error("engine write enable high while not busy");
    fail_count++;
  end

  err_on_completion: assert property (
    @(posedge clk) disable iff (rst) pslverr |-> (psel && penable && pready)
  ) else begin
    $error("pslverr high outside a completing transfer");
    fail_count++;
  end

endmodule

bind compute_core compute_core_properties u_properties (
  .clk    (clk),
  .rst    (rst),
  .busy   (busy),
  .done   (done),
  .wr_en  (wr_en),
  .psel   (psel),
  .penable(penable),
  .pready (pready),
  .pslverr(pslverr)
);

`default_nettype wire

/* compute_core.sv */
`timescale 1ns/1ns
`default_nettype none

module compute_core (
  input  logic                clk,
  input  logic                rst,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  core_pkg::apb_addr_t paddr,
  input  core_pkg::apb_data_t pwdata,
  output core_pkg::apb_data_t prdata,
  output logic                pready,
  output logic                pslverr,
  output logic                done
);

  core_pkg::region_t    region;
  core_pkg::coeff_idx_t word;
  core_pkg::opcode_t    cmd_op;
  core_pkg::opcode_t    op_reg;
  core_pkg::coeff_t     cmd_q;
  core_pkg::coeff_t     q_reg;
  core_pkg::coeff_t     host_rdata [3];
  core_pkg::coeff_t     eng_rdata [3];
  core_pkg::coeff_t     mac_result;
  core_pkg::coeff_idx_t rd_idx;
  core_pkg::coeff_idx_t wr_idx;
  core_pkg::apb_data_t  status;
  logic [1:0]           rd_cnt;
  logic access, poly_sel, poly_ok;
  logic cmd_access, cmd_err, cmd_accept;
  logic start_q, busy, busy_any, run, wr_en, issue_last, write_last;

  bank_if host_if [3] ();
  bank_if eng_if [3] ();

  assign region = paddr[9:8];
  assign word   = paddr[7:2];
  assign cmd_op = pwdata[2:0];
  assign cmd_q  = pwdata[19:3];

  assign access   = psel && penable;
  assign poly_sel = (region != core_pkg::REGION_CTRL);
  // a command counts as busy from acceptance on
  assign busy_any = busy || start_q;
  assign poly_ok  = access && poly_sel && !busy_any;

  // command write: word 0 of ctrl
  assign cmd_access = access && pwrite && !poly_sel && (word == '0);
  assign cmd_err    = busy_any || (cmd_q == '0) ||
                      (cmd_op != core_pkg::OP_PWM && cmd_op != core_pkg::OP_PMAC);
  assign cmd_accept = cmd_access && !cmd_err;
  assign pslverr    = cmd_access && cmd_err;

  // poly reads wait out the bank latency, busy stalls all poly traffic
  always_comb begin
    pready = 1'b0;
    if (access) begin
      if (!poly_sel) begin
        pready = 1'b1;
      end else if (!busy_any) begin
        pready = pwrite || (rd_cnt == 2'(core_pkg::BANK_RD_LAT));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_cnt  <= '0;
      start_q <= 1'b0;
      op_reg  <= '0;
      q_reg   <= '0;
    end else begin
      start_q <= cmd_accept;
      if (cmd_accept) begin
        op_reg <= cmd_op;
        q_reg  <= cmd_q;
      end
      if (poly_ok && !pwrite && !pready) begin
        rd_cnt <= rd_cnt + 1'b1;
      end else begin
        rd_cnt <= '0;
      end
    end
  end

  always_comb begin
    status = '0;
    status[core_pkg::STATUS_BUSY_BIT] = busy;
    status[core_pkg::STATUS_DONE_BIT] = done;
    case (region)
      core_pkg::REGION_A: prdata = core_pkg::apb_data_t'(host_rdata[0]);
      core_pkg::REGION_B: prdata = core_pkg::apb_data_t'(host_rdata[1]);
      core_pkg::REGION_C: prdata = core_pkg::apb_data_t'(host_rdata[2]);
      default: begin
        if (word == '0) begin
          prdata = core_pkg::apb_data_t'({q_reg, op_reg});
        end else if (word == core_pkg::coeff_idx_t'(1)) begin
          prdata = status;
        end else begin
          prdata = '0;
        end
      end
    endcase
  end

  // bank i sits in region i, only c takes engine writes
  for (genvar i = 0; i < 3; i++) begin : g_poly
    assign host_if[i].raddr = word;
    assign host_if[i].waddr = word;
    assign host_if[i].wdata = pwdata[core_pkg::COEFF_BITS-1:0];
    assign host_if[i].we    = poly_ok && pwrite && (region == core_pkg::region_t'(i));
    assign host_rdata[i]    = host_if[i].rdata;

    assign eng_if[i].raddr = rd_idx;
    assign eng_if[i].waddr = wr_idx;
    assign eng_if[i].wdata = mac_result;
    assign eng_if[i].we    = wr_en;
    assign eng_rdata[i]    = eng_if[i].rdata;

    poly_bank #(
      .ENGINE_WRITES(core_pkg::region_t'(i) == core_pkg::REGION_C)
    ) u_poly_bank (
      .clk   (clk),
      .busy  (busy),
      .host  (host_if[i]),
      .engine(eng_if[i])
    );
  end

  coeff_counter u_coeff_counter (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .rd_idx    (rd_idx),
    .wr_idx    (wr_idx),
    .wr_en     (wr_en),
    .issue_last(issue_last),
    .write_last(write_last)
  );

  mod_mac u_mod_mac (
    .clk       (clk),
    .a         (eng_rdata[0]),
    .b         (eng_rdata[1]),
    .c         (eng_rdata[2]),
    .q         (q_reg),
    .accumulate(op_reg == core_pkg::OP_PMAC),
    .result    (mac_result)
  );

  pwm_controller u_pwm_controller (
    .clk       (clk),
    .rst       (rst),
    .start     (start_q),
    .issue_last(issue_last),
    .write_last(write_last),
    .run       (run),
    .busy      (busy),
    .done      (done)
  );

endmodule

`default_nettype wire

/* pwm_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module pwm_controller (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic issue_last,
  input  logic write_last,
  output logic run,
  output logic busy,
  output logic done
);

  core_pkg::ctrl_state_t state;
  core_pkg::ctrl_state_t state_nxt;
  logic                  finish;

  always_comb begin
    state_nxt = state;
    finish    = 1'b0;
    case (state)
      core_pkg::IDLE: begin
        if (start) begin
          state_nxt = core_pkg::RUN;
        end
      end
      // indices go out one per cycle
      core_pkg::RUN: begin
        if (issue_last) begin
          state_nxt = core_pkg::DRAIN;
        end
      end
      // wait for the pipeline to flush into c
      core_pkg::DRAIN: begin
        if (write_last) begin
          state_nxt = core_pkg::IDLE;
          finish    = 1'b1;
        end
      end
      default: begin
        state_nxt = core_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= core_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // done holds until the next command starts
  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else if (start && state == core_pkg::IDLE) begin
      done <= 1'b0;
    end else if (finish) begin
      done <= 1'b1;
    end
  end

  assign run  = (state == core_pkg::RUN);
  assign busy = (state != core_pkg::IDLE);

endmodule

`default_nettype wire

/* mod_mac.sv */
`timescale 1ns/1ns
`default_nettype none

module mod_mac (
  input  logic             clk,
  input  core_pkg::coeff_t a,
  input  core_pkg::coeff_t b,
  input  core_pkg::coeff_t c,
  input  core_pkg::coeff_t q,
  input  logic             accumulate,
  output core_pkg::coeff_t result
);

  logic [2*core_pkg::COEFF_BITS-1:0] a_ext;
  logic [2*core_pkg::COEFF_BITS-1:0] b_ext;
  logic [2*core_pkg::COEFF_BITS-1:0] prod_q;
  logic [2*core_pkg::COEFF_BITS:0]   c_ext;
  logic [2*core_pkg::COEFF_BITS:0]   q_ext;
  logic [2*core_pkg::COEFF_BITS:0]   sum_q;
  logic [2*core_pkg::COEFF_BITS:0]   rem;
  core_pkg::coeff_t                  c_q;

  assign a_ext = {{core_pkg::COEFF_BITS{1'b0}}, a};
  assign b_ext = {{core_pkg::COEFF_BITS{1'b0}}, b};

  // c is delayed one stage to line up with the product
  assign c_ext = {{(core_pkg::COEFF_BITS + 1){1'b0}}, c_q};
  assign q_ext = {{(core_pkg::COEFF_BITS + 1){1'b0}}, q};

  // stage 1, full product
  always_ff @(posedge clk) begin
    prod_q <= a_ext * b_ext;
    c_q    <= c;
  end

  // stage 2, add old c for pmac
  always_ff @(posedge clk) begin
    sum_q <= {1'b0, prod_q} + (accumulate ? c_ext : '0);
  end

  // sum stays below q*q + q, so one remainder gives the final value
  assign rem = sum_q % q_ext;

  // stage 3
  always_ff @(posedge clk) begin
    result <= rem[core_pkg::COEFF_BITS-1:0];
  end

endmodule

`default_nettype wire

/* coeff_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module coeff_counter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 run,
  output core_pkg::coeff_idx_t rd_idx,
  output core_pkg::coeff_idx_t wr_idx,
  output logic                 wr_en,
  output logic                 issue_last,
  output logic                 write_last
);

  core_pkg::coeff_idx_t cnt;
  logic [core_pkg::BANK_RD_LAT+core_pkg::MAC_LAT-1:0] vld_pipe;
  core_pkg::coeff_idx_t idx_pipe [core_pkg::BANK_RD_LAT+core_pkg::MAC_LAT];

  // read side, one index per cycle while running
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt        <= '0;
      vld_pipe   <= '0;
      write_last <= 1'b0;
    end else begin
      cnt        <= run ? cnt + 1'b1 : '0;
      vld_pipe   <= {vld_pipe[core_pkg::BANK_RD_LAT+core_pkg::MAC_LAT-2:0], run};
      // flagged the cycle after the final write lands
      write_last <= wr_en && (&wr_idx);
    end
  end

  // index travels with the valid bit through memory and mac latency
  always_ff @(posedge clk) begin
    idx_pipe[0] <= cnt;
    for (int k = 1; k < core_pkg::BANK_RD_LAT + core_pkg::MAC_LAT; k++) begin
      idx_pipe[k] <= idx_pipe[k-1];
    end
  end

  assign rd_idx = cnt;

  // last index is all ones since N is a power of two
  assign issue_last = run && (&cnt);

  assign wr_idx = idx_pipe[core_pkg::BANK_RD_LAT+core_pkg::MAC_LAT-1];
  assign wr_en  = vld_pipe[core_pkg::BANK_RD_LAT+core_pkg::MAC_LAT-1];

endmodule

`default_nettype wire

/* poly_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module poly_bank #(
  parameter bit ENGINE_WRITES = 1'b0
) (
  input  logic   clk,
  input  logic   busy,
  bank_if.memory host,
  bank_if.memory engine
);

  core_pkg::coeff_t even_mem [core_pkg::N/2];
  core_pkg::coeff_t odd_mem  [core_pkg::N/2];

  core_pkg::coeff_t even_pipe [core_pkg::BANK_RD_LAT];
  core_pkg::coeff_t odd_pipe  [core_pkg::BANK_RD_LAT];
  logic [core_pkg::BANK_RD_LAT-1:0] sel_pipe;

  core_pkg::coeff_idx_t raddr;
  core_pkg::coeff_idx_t waddr;
  core_pkg::bank_addr_t rd_row;
  core_pkg::bank_addr_t wr_row;
  core_pkg::coeff_t     wdata;
  core_pkg::coeff_t     rdata;
  logic                 we;
  logic                 eng_wr;

  // engine takes the read port for the whole command
  // and the write port only on the result memory
  assign eng_wr = busy && ENGINE_WRITES;
  assign raddr  = busy ? engine.raddr : host.raddr;
  assign waddr  = eng_wr ? engine.waddr : host.waddr;
  assign wdata  = eng_wr ? engine.wdata : host.wdata;
  assign we     = eng_wr ? engine.we : host.we;

  // bit 0 picks the bank, the rest is the row
  assign rd_row = raddr[core_pkg::LOGN-1:1];
  assign wr_row = waddr[core_pkg::LOGN-1:1];

  always_ff @(posedge clk) begin
    if (we && !waddr[0]) begin
      even_mem[wr_row] <= wdata;
    end
    if (we && waddr[0]) begin
      odd_mem[wr_row] <= wdata;
    end
  end

  // both banks read every cycle, bank select rides along
  always_ff @(posedge clk) begin
    even_pipe[0] <= even_mem[rd_row];
    odd_pipe[0]  <= odd_mem[rd_row];
    sel_pipe[0]  <= raddr[0];
    for (int k = 1; k < core_pkg::BANK_RD_LAT; k++) begin
      even_pipe[k] <= even_pipe[k-1];
      odd_pipe[k]  <= odd_pipe[k-1];
      sel_pipe[k]  <= sel_pipe[k-1];
    end
  end

  // steer with the delayed select
  assign rdata = sel_pipe[core_pkg::BANK_RD_LAT-1] ? odd_pipe[core_pkg::BANK_RD_LAT-1]
                                                   : even_pipe[core_pkg::BANK_RD_LAT-1];

  assign host.rdata   = rdata;
  assign engine.rdata = rdata;

endmodule

`default_nettype wire

/* bank_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface bank_if;

  // addresses carry the row in the upper bits and the bank in bit 0
  core_pkg::coeff_idx_t raddr;
  core_pkg::coeff_t     rdata;
  core_pkg::coeff_idx_t waddr;
  core_pkg::coeff_t     wdata;
  logic                 we;

  modport requester (
    output raddr,
    output waddr,
    output wdata,
    output we,
    input  rdata
  );

  modport memory (
    input  raddr,
    input  waddr,
    input  wdata,
    input  we,
    output rdata
  );

endinterface

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;

  // polynomial geometry
  localparam int LOGN       = 6;
  localparam int N          = 1 << LOGN;
  localparam int COEFF_BITS = 17;

  // latencies in clock cycles
  localparam int BANK_RD_LAT = 2;
  localparam int MAC_LAT     = 3;

  // apb bus widths
  localparam int APB_ADDR_BITS = 10;
  localparam int APB_DATA_BITS = 32;

  typedef logic [COEFF_BITS-1:0]    coeff_t;
  typedef logic [LOGN-1:0]          coeff_idx_t;
  typedef logic [LOGN-2:0]          bank_addr_t;
  typedef logic [APB_ADDR_BITS-1:0] apb_addr_t;
  typedef logic [APB_DATA_BITS-1:0] apb_data_t;
  typedef logic [2:0]               opcode_t;
  typedef logic [1:0]               region_t;

  // command opcodes
  localparam opcode_t OP_PWM  = 3'd1;
  localparam opcode_t OP_PMAC = 3'd2;

  // paddr[9:8] decode
  localparam region_t REGION_A    = 2'd0;
  localparam region_t REGION_B    = 2'd1;
  localparam region_t REGION_C    = 2'd2;
  localparam region_t REGION_CTRL = 2'd3;

  // status word layout
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } ctrl_state_t;

endpackage

`default_nettype wire
